// ==== tests/rp_analog_golden.txt ====
# kind  p0 p1 p2 p3 e0 e1, all hex | adc: raw_a raw_b 0 0 conv_a conv_b
# dac: asg_a asg_b pid_a pid_b code_a code_b | loop: same inputs, sum_a sum_b
# wr: addr wdata 0 0 err led_o | rd: addr 0 0 0 rdata err | unlock: cycles 0 0 0 led_o dac_rst_o
adc 0000 ffff 0 0 1fff 2000
adc 8000 7ffc 0 0 3fff 0000
adc 1234 abcd 0 0 1b72 350c
adc 4001 c003 0 0 0fff 2fff
dac 0100 3f00 0023 0010 1edc 20ef
dac 1800 2000 0900 3fff 0000 3fff
dac 1fff 2000 0000 0001 0000 3ffe
dac 0fff 2800 1000 3000 0000 3fff
rd 00000000 0 0 0 52500001 0
wr 00000030 000000a5 0 0 0 a5
rd 00000030 0 0 0 000000a5 0
wr 00000000 12345678 0 0 0 a5
rd 00000000 0 0 0 52500001 0
wr 00000004 00000001 0 0 0 a5
loop 0100 3f00 0023 0010 0123 3f10
loop 1800 2000 0900 3fff 1fff 2000
wr 00000004 00000000 0 0 0 a5
adc 1234 abcd 0 0 1b72 350c
rd 00300000 0 0 0 00000000 1
wr 00300030 0000005a 0 0 1 a5
rd 00000010 0 0 0 00000000 1
wr 00000004 00000001 0 0 0 a5
unlock 00000025 0 0 0 00 1
rd 00000038 0 0 0 00000025 0
rd 00000004 0 0 0 00000000 0
rd 00000030 0 0 0 00000000 0

// ==== rp_analog.f ====
verilog/rp_stream_pkg.sv
verilog/rp_sys_bus_pkg.sv
verilog/rp_pll_monitor.sv
verilog/rp_adc_frontend.sv
verilog/rp_dac_backend.sv
verilog/rp_sys_bus_decoder.sv
verilog/rp_housekeeping.sv
verilog/rp_analog_top.sv
tests/rp_analog_top_props.sv
tests/tb_rp_analog_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rp_analog testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_analog_top -f rp_analog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rp_analog_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation run returned status $run_status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tests/tb_rp_analog_top.sv ====
//////////////////////////////////////////////////////////////////////
// Plays tests/rp_analog_golden.txt against the analog top level
// Run from the project root so the golden file path resolves
// Inputs change 1 ns after the rising edge, outputs sampled there too
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_rp_analog_top import rp_stream_pkg::*, rp_sys_bus_pkg::*; ();

  localparam int ACK_TIMEOUT = 8;     // Cycles allowed for a bus ack
  localparam int MAX_UNLOCK  = 1000;  // Longest unlock record accepted

  logic              adc_clk;
  logic              reset_i;
  logic              pll_locked_i;
  rp_adc_raw_pair_t  adc_raw_i;
  rp_sample_pair_t   asg_stream_i;
  rp_sample_pair_t   pid_stream_i;
  rp_sample_pair_t   adc_stream_o;
  rp_dac_code_pair_t dac_code_o;
  logic              dac_rst_o;
  logic [7:0]        led_o;
  rp_sys_req_t       sys_req_i;
  rp_sys_rsp_t       sys_rsp_o;

  int check_errors = 0;   // Whole run
  int test_errors  = 0;   // Current test only
  int tests_run    = 0;
  int tests_failed = 0;

  rp_analog_top #(.HK_ID (32'h5250_0001), .UNLOCK_CNT_W (32)) UUT (.*);

  // Bus timing assertions on the region decoder
  bind rp_sys_bus_decoder rp_analog_top_props i_props (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .req_i   (req_i),
    .rsp_i   (rsp_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge adc_clk);
    #1;  // Drive and sample point
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      check_errors++;
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    check_errors++;
    test_errors++;
  endtask

  task automatic start_test();
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test(input string label);
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s", tests_run, label, (test_errors == 0) ? "ok" : "failed");
  endtask

  // One strobe, then wait for the ack with a limit
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic is_write, output rp_sys_rsp_t rsp);
    int waits;
    sys_req_i.addr.raw = addr;
    sys_req_i.wdata    = wdata;
    sys_req_i.wen      = is_write;
    sys_req_i.ren      = ~is_write;
    next_cycle();                    // Strobe taken here
    sys_req_i.wen = 1'b0;
    sys_req_i.ren = 1'b0;
    waits = 1;
    while (!sys_rsp_o.ack && waits < ACK_TIMEOUT) begin
      next_cycle();
      waits++;
    end
    rsp = sys_rsp_o;
    if (!sys_rsp_o.ack) begin
      report_error($sformatf("Timeout: no bus ack for address %h", addr));
    end else begin
      check_value("ack latency", waits, 1);
    end
    next_cycle();  // Idle gap
  endtask

  //////////////////////////////////////////////////////////////////////
  // One golden record
  //////////////////////////////////////////////////////////////////////

  task automatic run_record(input logic [63:0] kind,
                            input logic [31:0] p0, p1, p2, p3, e0, e1);
    string       label;
    rp_sys_rsp_t rsp;
    start_test();
    label = "unknown record";
    if (kind == "adc") begin
      label = "adc conversion";
      adc_raw_i = {p1[15:0], p0[15:0]};
      repeat (2) next_cycle();       // Capture, then convert
      check_value("adc_stream_o.ch_a", {18'b0, adc_stream_o.ch_a}, e0);
      check_value("adc_stream_o.ch_b", {18'b0, adc_stream_o.ch_b}, e1);
    end else if (kind == "dac" || kind == "loop") begin
      asg_stream_i = {p1[13:0], p0[13:0]};
      pid_stream_i = {p3[13:0], p2[13:0]};
      if (kind == "dac") begin
        label = "dac sum";
        next_cycle();
        check_value("dac_code_o.ch_a", {18'b0, dac_code_o.ch_a}, e0);
        check_value("dac_code_o.ch_b", {18'b0, dac_code_o.ch_b}, e1);
      end else begin
        label = "loopback";
        #1;                           // Sum reaches the ADC side unregistered
        check_value("adc_stream_o.ch_a", {18'b0, adc_stream_o.ch_a}, e0);
        check_value("adc_stream_o.ch_b", {18'b0, adc_stream_o.ch_b}, e1);
        next_cycle();
      end
    end else if (kind == "wr") begin
      label = "bus write";
      bus_access(p0, p1, 1'b1, rsp);
      check_value("sys_rsp_o.err", rsp.err, e0);
      check_value("led_o", led_o, e1);
    end else if (kind == "rd") begin
      label = "bus read";
      bus_access(p0, '0, 1'b0, rsp);
      check_value("sys_rsp_o.rdata", rsp.rdata, e0);
      check_value("sys_rsp_o.err", rsp.err, e1);
    end else if (kind == "unlock") begin
      label = "pll unlock";
      if (p0 == 0 || p0 > MAX_UNLOCK) begin
        report_error("Unlock length in the golden file is out of range");
      end else begin
        pll_locked_i = 1'b0;
        repeat (p0) next_cycle();    // One count per unlocked edge
        check_value("dac_rst_o", dac_rst_o, e1);
        pll_locked_i = 1'b1;
        next_cycle();                // Last reset edge, internal reset drops
        check_value("led_o", led_o, e0);
        check_value("dac_rst_o", dac_rst_o, 0);
      end
    end else begin
      report_error("Unknown record kind in the golden file");
    end
    end_test(label);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int            fd;
    logic          done;
    logic [63:0]   kind;
    logic [1023:0] rest;
    logic [31:0]   p0, p1, p2, p3, e0, e1;
    reset_i      = 1'b1;
    pll_locked_i = 1'b1;
    adc_raw_i    = '0;
    asg_stream_i = '0;
    pid_stream_i = '0;
    sys_req_i    = '0;
    repeat (5) next_cycle();         // Reset held 5 cycles

    start_test();
    check_value("dac_rst_o", dac_rst_o, 1);
    check_value("sys_rsp_o.ack", sys_rsp_o.ack, 0);
    check_value("sys_rsp_o.err", sys_rsp_o.err, 0);
    check_value("led_o", led_o, 0);
    check_value("dac_code_o", dac_code_o, 0);
    end_test("reset state");
    reset_i = 1'b0;
    repeat (2) next_cycle();         // Internal reset follows one edge later

    fd = $fopen("tests/rp_analog_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file tests/rp_analog_golden.txt");
      check_errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        if ($fscanf(fd, "%s", kind) != 1) begin
          done = 1'b1;                 // End of file
        end else if (kind == "#") begin
          void'($fgets(rest, fd));     // Column notes
        end else if ($fscanf(fd, "%h %h %h %h %h %h", p0, p1, p2, p3, e0, e1) != 6) begin
          $display("Malformed golden record after test %0d", tests_run);
          check_errors++;
          done = 1'b1;
        end else begin
          run_record(kind, p0, p1, p2, p3, e0, e1);
        end
      end
      $fclose(fd);
    end

    $display("Tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, check_errors);
    if (check_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/rp_analog_top_props.sv ====
//////////////////////////////////////////////////////////////////////
// Bus timing checks, bound into the system bus region decoder
// Checks are off while the internal reset is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_analog_top_props import rp_sys_bus_pkg::*; (
  input logic        adc_clk,
  input logic        reset_i,   // Decoder reset
  input rp_sys_req_t req_i,     // Master request
  input rp_sys_rsp_t rsp_i      // Decoder response to master
);

  logic strobe;

  assign strobe = req_i.wen | req_i.ren;

  // Ack exactly one cycle after a strobe
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    strobe |=> rsp_i.ack)
    else $error("bus ack missing one cycle after a strobe");

  // No ack without a strobe in the cycle before
  no_stray_ack: assert property (@(posedge adc_clk) disable iff (reset_i)
    rsp_i.ack |-> $past(strobe))
    else $error("bus ack without a preceding strobe");

  one_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(req_i.wen && req_i.ren))  // Write and read exclusive
    else $error("write and read strobes high together");

endmodule

`default_nettype wire

// ==== verilog/rp_analog_top.sv ====
//////////////////////////////////////////////////////////////////////
// Analog glue top: ADC capture, DAC sum, housekeeping bus
// Single clock adc_clk; dac_rst_o follows the internal reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_analog_top import rp_stream_pkg::*, rp_sys_bus_pkg::*; #(
  parameter logic [SYS_DATA_W-1:0] HK_ID        = 32'h5250_0001,
  parameter int unsigned           UNLOCK_CNT_W = 32
)(
  input  logic              adc_clk,
  input  logic              reset_i,
  input  logic              pll_locked_i,
  // Streams
  input  rp_adc_raw_pair_t  adc_raw_i,     // ADC pins
  input  rp_sample_pair_t   asg_stream_i,  // Generator
  input  rp_sample_pair_t   pid_stream_i,  // Controller
  output rp_sample_pair_t   adc_stream_o,
  output rp_dac_code_pair_t dac_code_o,    // DAC pins
  output logic              dac_rst_o,
  output logic [7:0]        led_o,
  // System bus
  input  rp_sys_req_t       sys_req_i,
  output rp_sys_rsp_t       sys_rsp_o
);

  logic                    rst_int;       // Reset or PLL unlocked
  logic [UNLOCK_CNT_W-1:0] unlock_cnt;
  logic                    digital_loop;
  rp_sample_pair_t         dac_sum;       // Saturated sum, loopback source
  rp_sys_req_t             hk_req;
  rp_sys_rsp_t             hk_rsp;

  //////////////////////////////////////////////////////////////////////
  // PLL lock and reset
  //////////////////////////////////////////////////////////////////////

  rp_pll_monitor #(.UNLOCK_CNT_W (UNLOCK_CNT_W)) i_pll_mon (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),       // Counter clears on external reset only
    .pll_locked_i (pll_locked_i),
    .rst_int_o    (rst_int),
    .unlock_cnt_o (unlock_cnt)
  );

  assign dac_rst_o = rst_int;

  //////////////////////////////////////////////////////////////////////
  // ADC and DAC streams
  //////////////////////////////////////////////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk      (adc_clk),
    .reset_i      (rst_int),
    .adc_raw_i    (adc_raw_i),
    .loop_i       (digital_loop),
    .loop_dat_i   (dac_sum),
    .adc_stream_o (adc_stream_o)
  );

  rp_dac_backend i_dac (
    .adc_clk    (adc_clk),
    .reset_i    (rst_int),
    .asg_i      (asg_stream_i),
    .pid_i      (pid_stream_i),
    .dac_sum_o  (dac_sum),
    .dac_code_o (dac_code_o)
  );

  //////////////////////////////////////////////////////////////////////
  // System bus and housekeeping
  //////////////////////////////////////////////////////////////////////

  rp_sys_bus_decoder i_bus_dec (
    .adc_clk  (adc_clk),
    .reset_i  (rst_int),
    .req_i    (sys_req_i),
    .rsp_o    (sys_rsp_o),
    .hk_req_o (hk_req),
    .hk_rsp_i (hk_rsp)
  );

  rp_housekeeping #(
    .HK_ID        (HK_ID),
    .UNLOCK_CNT_W (UNLOCK_CNT_W)
  ) i_hk (
    .adc_clk        (adc_clk),
    .reset_i        (rst_int),
    .req_i          (hk_req),
    .rsp_o          (hk_rsp),
    .unlock_cnt_i   (unlock_cnt),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

endmodule

`default_nettype wire

// ==== verilog/rp_housekeeping.sv ====
//////////////////////////////////////////////////////////////////////
// Housekeeping registers: ID, loopback enable, LEDs, unlock count
// Writes to read-only registers are dropped without error
// Unknown offsets ack with err set and rdata zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_housekeeping import rp_sys_bus_pkg::*; #(
  parameter logic [SYS_DATA_W-1:0] HK_ID        = '0,   // Identification word
  parameter int unsigned           UNLOCK_CNT_W = 32
)(
  input  logic                    adc_clk,
  input  logic                    reset_i,         // Internal reset
  input  rp_sys_req_t             req_i,           // Strobes already decoded
  output rp_sys_rsp_t             rsp_o,
  input  logic [UNLOCK_CNT_W-1:0] unlock_cnt_i,    // PLL unlock cycles
  output logic                    digital_loop_o,  // Loopback enable
  output logic [7:0]              led_o
);

  // Register map
  localparam logic [SYS_OFFSET_W-1:0] OFS_ID     = 'h00;
  localparam logic [SYS_OFFSET_W-1:0] OFS_LOOP   = 'h04;
  localparam logic [SYS_OFFSET_W-1:0] OFS_LED    = 'h30;
  localparam logic [SYS_OFFSET_W-1:0] OFS_UNLOCK = 'h38;

  logic [SYS_OFFSET_W-1:0] ofs;
  logic                    known;     // Offset is mapped
  logic [SYS_DATA_W-1:0]   rd_mux;
  logic                    ack_q;
  logic                    err_q;
  logic [SYS_DATA_W-1:0]   rdata_q;

  assign ofs = req_i.addr.fld.offset;

  //////////////////////////////////////////////////////////////////////
  // Read mux and offset check
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    known  = 1'b1;
    rd_mux = '0;
    case (ofs)
      OFS_ID:     rd_mux = HK_ID;
      OFS_LOOP:   rd_mux = SYS_DATA_W'(digital_loop_o);
      OFS_LED:    rd_mux = SYS_DATA_W'(led_o);
      OFS_UNLOCK: rd_mux = SYS_DATA_W'(unlock_cnt_i);  // Zero extended or cut
      default:    known  = 1'b0;
    endcase
  end

  // Writable registers
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end else if (req_i.wen) begin
      case (ofs)
        OFS_LOOP: digital_loop_o <= req_i.wdata[0];
        OFS_LED:  led_o          <= req_i.wdata[7:0];
        default: ;  // ID and count are read only
      endcase
    end
  end

  // Ack and err one cycle after any strobe
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_i.wen | req_i.ren;
      err_q <= (req_i.wen | req_i.ren) & ~known;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req_i.ren) begin
      rdata_q <= rd_mux;  // Zero for unknown offsets
    end
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule

`default_nettype wire

// ==== verilog/rp_sys_bus_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// System bus region decoder, only region 0 has a target
// Other regions ack one cycle later with err set and rdata zero
// Assumes no second strobe before the ack of the first
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_sys_bus_decoder import rp_sys_bus_pkg::*; (
  input  logic        adc_clk,
  input  logic        reset_i,     // Internal reset
  input  rp_sys_req_t req_i,       // From master
  output rp_sys_rsp_t rsp_o,       // To master
  output rp_sys_req_t hk_req_o,    // To housekeeping
  input  rp_sys_rsp_t hk_rsp_i     // From housekeeping
);

  logic                    strobe;     // Any access this cycle
  logic                    hit_hk;     // Region 0 addressed
  logic [SYS_REGION_W-1:0] region_q;   // Region of the pending access
  logic                    err_ack_q;  // Ack for unmapped regions

  assign strobe = req_i.wen | req_i.ren;
  assign hit_hk = (req_i.addr.fld.region == REGION_HK);

  // Address and data pass through, strobes only on a hit
  always_comb begin
    hk_req_o     = req_i;
    hk_req_o.wen = req_i.wen & hit_hk;
    hk_req_o.ren = req_i.ren & hit_hk;
  end

  //////////////////////////////////////////////////////////////////////
  // Pending region and error answer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      region_q  <= REGION_HK;
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= strobe & ~hit_hk;  // One cycle pulse
      if (strobe) begin
        region_q <= req_i.addr.fld.region;
      end
    end
  end

  // Response mux follows the remembered region
  always_comb begin
    if (region_q == REGION_HK) begin
      rsp_o = hk_rsp_i;
    end else begin
      rsp_o.rdata = '0;
      rsp_o.ack   = err_ack_q;
      rsp_o.err   = err_ack_q;  // Unmapped region
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rp_dac_backend.sv ====
//////////////////////////////////////////////////////////////////////
// DAC sum of generator and controller streams, per channel
// Sum saturates to 14 bits; output code is registered once
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_dac_backend import rp_stream_pkg::*; (
  input  logic              adc_clk,
  input  logic              reset_i,      // Internal reset
  input  rp_sample_pair_t   asg_i,        // Generator stream
  input  rp_sample_pair_t   pid_i,        // Controller stream
  output rp_sample_pair_t   dac_sum_o,    // Saturated sum, no register
  output rp_dac_code_pair_t dac_code_o    // Offset code to pins
);

  // Add in 15 bits, clamp when the top two bits disagree
  function automatic rp_sample_t sat_sum(input rp_sample_t a, input rp_sample_t b);
    logic signed [SAMPLE_W:0] sum;
    sum = a + b;
    if (sum[SAMPLE_W] != sum[SAMPLE_W-1]) begin
      return rp_sample_t'({sum[SAMPLE_W], {(SAMPLE_W-1){~sum[SAMPLE_W]}}});
    end
    return sum[SAMPLE_W-1:0];
  endfunction

  // Two's complement to negative slope offset code
  function automatic logic [SAMPLE_W-1:0] twos_to_code(input rp_sample_t s);
    return {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

  always_comb begin
    dac_sum_o.ch_a = sat_sum(asg_i.ch_a, pid_i.ch_a);
    dac_sum_o.ch_b = sat_sum(asg_i.ch_b, pid_i.ch_b);
  end

  // Output register, both channels leave together
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_code_o <= '0;
    end else begin
      dac_code_o.ch_a <= twos_to_code(dac_sum_o.ch_a);
      dac_code_o.ch_b <= twos_to_code(dac_sum_o.ch_b);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rp_adc_frontend.sv ====
//////////////////////////////////////////////////////////////////////
// ADC capture, two register stages from pins to stream
// Loopback select is combinational after the second stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_adc_frontend import rp_stream_pkg::*; (
  input  logic             adc_clk,
  input  logic             reset_i,       // Internal reset
  input  rp_adc_raw_pair_t adc_raw_i,     // Raw converter words
  input  logic             loop_i,        // Digital loopback enable
  input  rp_sample_pair_t  loop_dat_i,    // DAC side saturated sum
  output rp_sample_pair_t  adc_stream_o
);

  logic [SAMPLE_W-1:0] raw_a_q;   // Stage 1, channel A
  logic [SAMPLE_W-1:0] raw_b_q;   // Stage 1, channel B
  rp_sample_pair_t     conv_q;    // Stage 2, two's complement

  // Negative slope code into two's complement
  function automatic rp_sample_t slope_to_twos(input logic [SAMPLE_W-1:0] code);
    return rp_sample_t'({code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]});
  endfunction

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
      conv_q  <= '0;
    end else begin
      // Lowest 2 bits unused on a 14 bit converter
      raw_a_q     <= adc_raw_i.ch_a[ADC_RAW_W-1 -: SAMPLE_W];
      raw_b_q     <= adc_raw_i.ch_b[ADC_RAW_W-1 -: SAMPLE_W];
      conv_q.ch_a <= slope_to_twos(raw_a_q);
      conv_q.ch_b <= slope_to_twos(raw_b_q);
    end
  end

  // Loopback replaces both channels at once
  assign adc_stream_o = loop_i ? loop_dat_i : conv_q;

endmodule

`default_nettype wire

// ==== verilog/rp_pll_monitor.sv ====
//////////////////////////////////////////////////////////////////////
// Internal reset while the PLL is unlocked, plus unlock counter
// Counter is cleared by the external reset only and wraps
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_pll_monitor #(
  parameter int unsigned UNLOCK_CNT_W = 32
)(
  input  logic                    adc_clk,
  input  logic                    reset_i,       // External reset
  input  logic                    pll_locked_i,  // Lock level
  output logic                    rst_int_o,     // Internal reset, active high
  output logic [UNLOCK_CNT_W-1:0] unlock_cnt_o
);

  // Combined reset, one register
  always_ff @(posedge adc_clk) begin
    rst_int_o <= reset_i | ~pll_locked_i;
  end

  // Survives the lock reset, readable after relock
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      unlock_cnt_o <= '0;
    end else if (!pll_locked_i) begin
      unlock_cnt_o <= unlock_cnt_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rp_sys_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// System bus types: single-cycle strobes, ack one cycle later
// Address splits into 8 regions of 1 MB each, upper 9 bits ignored
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rp_sys_bus_pkg;

  localparam int unsigned SYS_ADDR_W   = 32;  // Byte address
  localparam int unsigned SYS_DATA_W   = 32;
  localparam int unsigned SYS_OFFSET_W = 20;  // Offset inside a region
  localparam int unsigned SYS_REGION_N = 8;

  localparam int unsigned SYS_REGION_W = $clog2(SYS_REGION_N);
  localparam int unsigned SYS_PAD_W    = SYS_ADDR_W - SYS_REGION_W - SYS_OFFSET_W;

  localparam logic [SYS_REGION_W-1:0] REGION_HK = '0;  // Housekeeping

  // Decoded view of the address
  typedef struct packed {
    logic [SYS_PAD_W-1:0]    unused;
    logic [SYS_REGION_W-1:0] region;
    logic [SYS_OFFSET_W-1:0] offset;
  } rp_sys_addr_fields_t;

  // Same word, raw or split
  typedef union packed {
    logic [SYS_ADDR_W-1:0] raw;
    rp_sys_addr_fields_t   fld;
  } rp_sys_addr_u;

  // Master to target
  typedef struct packed {
    rp_sys_addr_u          addr;
    logic [SYS_DATA_W-1:0] wdata;
    logic                  wen;    // One cycle write strobe
    logic                  ren;    // One cycle read strobe
  } rp_sys_req_t;

  // Target to master
  typedef struct packed {
    logic [SYS_DATA_W-1:0] rdata;
    logic                  ack;    // One cycle after strobe
    logic                  err;
  } rp_sys_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/rp_stream_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Two-channel ADC and DAC stream formats on adc_clk
// Raw ADC words are 16 bit wide and only the upper 14 bits carry data
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rp_stream_pkg;

  localparam int unsigned ADC_RAW_W = 16;  // Converter bus width
  localparam int unsigned SAMPLE_W  = 14;  // Stream sample width

  // Two's complement stream sample
  typedef logic signed [SAMPLE_W-1:0] rp_sample_t;

  // Sample pair, channel A in the low half
  typedef struct packed {
    rp_sample_t ch_b;
    rp_sample_t ch_a;
  } rp_sample_pair_t;

  // Raw converter words, negative slope code
  typedef struct packed {
    logic [ADC_RAW_W-1:0] ch_b;
    logic [ADC_RAW_W-1:0] ch_a;
  } rp_adc_raw_pair_t;

  // Offset code for the DAC pins
  typedef struct packed {
    logic [SAMPLE_W-1:0] ch_b;
    logic [SAMPLE_W-1:0] ch_a;
  } rp_dac_code_pair_t;

endpackage

`default_nettype wire
